// File: cache/backend_arbiter.sv
module backend_arbiter (
   input  logic                  clk_i,
   input  logic                  rst_i,
   input  logic                  fill_req_i,
   input  cache_pkg::addr_t      fill_addr_i,
   output logic                  fill_ack_o,
   output cache_pkg::word_t      fill_rdata_o,
   input  logic                  wtb_valid_i,
   input  cache_pkg::wtb_entry_t wtb_head_i,
   output logic                  wtb_pop_o,
   output logic                  be_req_o,
   output cache_pkg::addr_t      be_addr_o,
   output cache_pkg::word_t      be_wdata_o,
   output cache_pkg::strb_t      be_wstrb_o,
   input  cache_pkg::word_t      be_rdata_i,
   input  logic                  be_ack_i
);
   logic lock_q;
   logic lock_fill_q;
   logic use_fill;

   // Fill wins when free. The lock keeps the owner until its acknowledge.
   assign use_fill = lock_q ? lock_fill_q : fill_req_i;

   assign be_req_o   = use_fill ? fill_req_i : wtb_valid_i;
   assign be_addr_o  = use_fill ? fill_addr_i : wtb_head_i.addr;
   assign be_wdata_o = wtb_head_i.data;
   assign be_wstrb_o = use_fill ? '0 : wtb_head_i.strb;

   assign fill_ack_o   = use_fill && be_ack_i;
   assign fill_rdata_o = be_rdata_i;
   assign wtb_pop_o    = !use_fill && be_ack_i;

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         lock_q      <= 1'b0;
         lock_fill_q <= 1'b0;
      end else if (be_ack_i) begin
         lock_q <= 1'b0;
      end else if (be_req_o) begin
         lock_q      <= 1'b1;
         lock_fill_q <= use_fill;
      end
   end

endmodule

// File: cache/cache_control.sv
module cache_control (
   input  logic                   clk_i,
   input  logic                   rst_i,
   input  logic                   req_i,
   input  cache_pkg::addr_t       addr_i,
   input  cache_pkg::word_t       wdata_i,
   input  cache_pkg::strb_t       wstrb_i,
   output cache_pkg::word_t       rdata_o,
   output logic                   ack_o,
   input  logic                   invalidate_i,
   input  logic                   hit_i,
   input  cache_pkg::word_t       line_word_i,
   output logic                   mem_we_o,
   output logic                   mem_fill_o,
   output cache_pkg::index_t      mem_index_o,
   output cache_pkg::offset_t     mem_offset_o,
   output cache_pkg::tag_t        mem_tag_o,
   output cache_pkg::word_t       mem_wdata_o,
   output cache_pkg::strb_t       mem_wstrb_o,
   output logic                   mem_invalidate_o,
   output logic                   wtb_push_o,
   output cache_pkg::wtb_entry_t  wtb_entry_o,
   input  logic                   wtb_full_i,
   input  logic                   wtb_empty_i,
   output logic                   fill_req_o,
   output cache_pkg::addr_t       fill_addr_o,
   input  cache_pkg::word_t       fill_rdata_i,
   input  logic                   fill_ack_i
);
   import cache_pkg::*;

   ctrl_state_e state_q;
   ctrl_state_e state_d;
   offset_t     fill_cnt_q;
   word_t       rdata_q;
   logic        inv_pend_q;
   logic        is_write;
   tag_t        req_tag;
   index_t      req_index;
   offset_t     req_offset;
   logic        fill_last;

   assign req_tag    = addr_i[$bits(addr_t)-1 -: $bits(tag_t)];
   assign req_index  = addr_i[$bits(offset_t) +: $bits(index_t)];
   assign req_offset = addr_i[$bits(offset_t)-1:0];
   assign is_write   = |wstrb_i;
   assign fill_last  = (fill_cnt_q == '1);

   always_comb begin
      state_d = state_q;
      case (state_q)
         ST_IDLE: begin
            if (req_i) state_d = ST_LOOKUP;
         end
         ST_LOOKUP: begin
            if (is_write) begin
               if (!wtb_full_i) state_d = ST_IDLE;
            end else if (hit_i) begin
               state_d = ST_IDLE;
            end else begin
               state_d = ST_WAIT_BUFFER;
            end
         end
         // Drain pending writes before the line is read back.
         ST_WAIT_BUFFER: begin
            if (wtb_empty_i) state_d = ST_FILL;
         end
         ST_FILL: begin
            if (fill_ack_i && fill_last) state_d = ST_RESPOND;
         end
         ST_RESPOND: state_d = ST_IDLE;
         default: state_d = ST_IDLE;
      endcase
   end

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         state_q    <= ST_IDLE;
         fill_cnt_q <= '0;
         inv_pend_q <= 1'b0;
      end else begin
         state_q <= state_d;
         if (state_q == ST_WAIT_BUFFER) begin
            fill_cnt_q <= '0;
         end else if (state_q == ST_FILL && fill_ack_i) begin
            fill_cnt_q <= fill_cnt_q + 1'b1;
         end
         // Held until the controller is back in idle.
         inv_pend_q <= (invalidate_i || inv_pend_q) && (state_q != ST_IDLE);
      end
   end

   always_ff @(posedge clk_i) begin
      if (state_q == ST_FILL && fill_ack_i && fill_cnt_q == req_offset) begin
         rdata_q <= fill_rdata_i;
      end
   end

   assign ack_o = (state_q == ST_RESPOND) ||
                  (state_q == ST_LOOKUP && is_write && !wtb_full_i) ||
                  (state_q == ST_LOOKUP && !is_write && hit_i);
   assign rdata_o = (state_q == ST_LOOKUP) ? line_word_i : rdata_q;

   assign mem_invalidate_o = (state_q == ST_IDLE) && (invalidate_i || inv_pend_q);
   assign mem_index_o  = req_index;
   assign mem_tag_o    = req_tag;
   assign mem_offset_o = (state_q == ST_FILL) ? fill_cnt_q : req_offset;
   assign mem_wdata_o  = (state_q == ST_FILL) ? fill_rdata_i : wdata_i;
   assign mem_wstrb_o  = (state_q == ST_FILL) ? '1 : wstrb_i;
   assign mem_we_o = (state_q == ST_LOOKUP && is_write && hit_i && !wtb_full_i) ||
                     (state_q == ST_FILL && fill_ack_i);
   assign mem_fill_o = (state_q == ST_FILL) && fill_ack_i && fill_last;

   assign wtb_push_o       = (state_q == ST_LOOKUP) && is_write && !wtb_full_i;
   assign wtb_entry_o.addr = addr_i;
   assign wtb_entry_o.data = wdata_i;
   assign wtb_entry_o.strb = wstrb_i;

   assign fill_req_o  = (state_q == ST_FILL);
   assign fill_addr_o = {req_tag, req_index, fill_cnt_q};

   a_ack_needs_req: assert property (@(posedge clk_i) disable iff (rst_i)
      ack_o |-> req_i);

   a_fill_after_drain: assert property (@(posedge clk_i) disable iff (rst_i)
      fill_req_o |-> wtb_empty_i);

endmodule

// File: cache/cache_memory.sv
`include "cache_settings.svh"

module cache_memory (
   input  logic               clk_i,
   input  logic               rst_i,
   input  cache_pkg::index_t  index_i,
   input  cache_pkg::offset_t offset_i,
   input  cache_pkg::tag_t    tag_i,
   input  logic               we_i,
   input  logic               fill_i,
   input  cache_pkg::word_t   wdata_i,
   input  cache_pkg::strb_t   wstrb_i,
   input  logic               invalidate_i,
   output logic               hit_o,
   output cache_pkg::word_t   rdata_o
);
   import cache_pkg::*;

   localparam int NLINES = 1 << `CACHE_NLINES_W;
   localparam int NWORDS = 1 << (`CACHE_NLINES_W + `CACHE_WORD_OFFSET_W);

   logic [NLINES-1:0] valid_q;
   tag_t              tags_q [NLINES];
   word_t             data_q [NWORDS];
   logic [$bits(index_t)+$bits(offset_t)-1:0] word_addr;

   assign word_addr = {index_i, offset_i};

   assign hit_o   = valid_q[index_i] && (tags_q[index_i] == tag_i);
   assign rdata_o = data_q[word_addr];

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         valid_q <= '0;
      end else if (invalidate_i) begin
         valid_q <= '0;
      end else if (fill_i) begin
         valid_q[index_i] <= 1'b1;
      end
   end

   // Tag goes in with the last word of a fill.
   always_ff @(posedge clk_i) begin
      if (fill_i) begin
         tags_q[index_i] <= tag_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (we_i) begin
         for (int b = 0; b < $bits(strb_t); b++) begin
            if (wstrb_i[b]) data_q[word_addr][8*b +: 8] <= wdata_i[8*b +: 8];
         end
      end
   end

endmodule

// File: cache/write_through_buffer.sv
`include "cache_settings.svh"

module write_through_buffer (
   input  logic                  clk_i,
   input  logic                  rst_i,
   input  logic                  push_i,
   input  cache_pkg::wtb_entry_t entry_i,
   output logic                  full_o,
   output logic                  empty_o,
   output cache_pkg::wtb_entry_t head_o,
   input  logic                  pop_i
);
   import cache_pkg::*;

   localparam int DEPTH = 1 << `CACHE_WTBUF_DEPTH_W;

   wtb_entry_t                    entries_q [DEPTH];
   logic [`CACHE_WTBUF_DEPTH_W-1:0] wr_ptr_q;
   logic [`CACHE_WTBUF_DEPTH_W-1:0] rd_ptr_q;
   logic [`CACHE_WTBUF_DEPTH_W:0]   count_q;
   logic                          do_push;
   logic                          do_pop;

   assign full_o  = (count_q == DEPTH[`CACHE_WTBUF_DEPTH_W:0]);
   assign empty_o = (count_q == '0);
   assign head_o  = entries_q[rd_ptr_q];

   // A push into a full buffer is dropped.
   assign do_push = push_i && !full_o;
   assign do_pop  = pop_i && !empty_o;

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (do_push) wr_ptr_q <= wr_ptr_q + 1'b1;
         if (do_pop) rd_ptr_q <= rd_ptr_q + 1'b1;
         case ({do_push, do_pop})
            2'b10: count_q <= count_q + 1'b1;
            2'b01: count_q <= count_q - 1'b1;
            default: count_q <= count_q;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (do_push) begin
         entries_q[wr_ptr_q] <= entry_i;
      end
   end

   a_no_push_full: assert property (@(posedge clk_i) disable iff (rst_i)
      push_i |-> !full_o);

   a_no_pop_empty: assert property (@(posedge clk_i) disable iff (rst_i)
      pop_i |-> !empty_o);

endmodule

// File: common/cache_pkg.sv
`include "cache_settings.svh"

package cache_pkg;

   typedef logic [`CACHE_DATA_W-1:0] word_t;
   typedef logic [`CACHE_STRB_W-1:0] strb_t;
   typedef logic [`CACHE_ADDR_W-1:0] addr_t;

   // Address split is tag, index, offset from the top down.
   typedef logic [`CACHE_ADDR_W-`CACHE_NLINES_W-`CACHE_WORD_OFFSET_W-1:0] tag_t;
   typedef logic [`CACHE_NLINES_W-1:0] index_t;
   typedef logic [`CACHE_WORD_OFFSET_W-1:0] offset_t;

   // One pending write on its way to memory.
   typedef struct packed {
      addr_t addr;
      word_t data;
      strb_t strb;
   } wtb_entry_t;

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_LOOKUP,
      ST_WAIT_BUFFER,
      ST_FILL,
      ST_RESPOND
   } ctrl_state_e;

endpackage

// File: common/cache_settings.svh
`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

// Word address width, in words.
`define CACHE_ADDR_W 12

// Data word width.
`define CACHE_DATA_W 32

// One byte enable per byte of a word.
`define CACHE_STRB_W (`CACHE_DATA_W / 8)

// Number of index bits, so 16 lines.
`define CACHE_NLINES_W 4

// Number of word-in-line bits, so 4 words per line.
`define CACHE_WORD_OFFSET_W 2

// Write-through buffer holds 2**depth entries.
`define CACHE_WTBUF_DEPTH_W 2

`endif

// File: run_sim.sh
#!/bin/sh
# Compile and run the cache testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f \
   --top-module tb_cache_subsystem -Mdir obj_dir
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

out=$(./obj_dir/Vtb_cache_subsystem 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -q "^TEST RESULT: PASS$"; then
   exit 0
fi
exit 1

// File: source/backend_ram.sv
`include "cache_settings.svh"

module backend_ram (
   input  logic             clk_i,
   input  logic             rst_i,
   input  logic             req_i,
   input  cache_pkg::addr_t addr_i,
   input  cache_pkg::word_t wdata_i,
   input  cache_pkg::strb_t wstrb_i,
   output cache_pkg::word_t rdata_o,
   output logic             ack_o
);
   import cache_pkg::*;

   localparam int NWORDS = 1 << `CACHE_ADDR_W;

   word_t mem [NWORDS];
   word_t rdata_q;
   logic  ack_q;
   logic  access;

   initial begin
      for (int i = 0; i < NWORDS; i++) mem[i] = '0;
   end

   // One access per request; the acknowledge cycle itself is skipped.
   assign access = req_i && !ack_q;

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) ack_q <= 1'b0;
      else ack_q <= access;
   end

   always_ff @(posedge clk_i) begin
      if (access) begin
         rdata_q <= mem[addr_i];
         for (int b = 0; b < $bits(strb_t); b++) begin
            if (wstrb_i[b]) mem[addr_i][8*b +: 8] <= wdata_i[8*b +: 8];
         end
      end
   end

   assign rdata_o = rdata_q;
   assign ack_o   = ack_q;

endmodule

// File: source/cache_subsystem.sv
module cache_subsystem (
   input  logic             clk_i,
   input  logic             rst_i,
   input  logic             req_i,
   input  cache_pkg::addr_t addr_i,
   input  cache_pkg::word_t wdata_i,
   input  cache_pkg::strb_t wstrb_i,
   output cache_pkg::word_t rdata_o,
   output logic             ack_o,
   input  logic             invalidate_i,
   output logic             wtb_empty_o
);
   import cache_pkg::*;

   logic       hit;
   word_t      line_word;
   logic       mem_we;
   logic       mem_fill;
   index_t     mem_index;
   offset_t    mem_offset;
   tag_t       mem_tag;
   word_t      mem_wdata;
   strb_t      mem_wstrb;
   logic       mem_invalidate;
   logic       wtb_push;
   wtb_entry_t wtb_entry;
   wtb_entry_t wtb_head;
   logic       wtb_full;
   logic       wtb_empty;
   logic       wtb_pop;
   logic       fill_req;
   addr_t      fill_addr;
   word_t      fill_rdata;
   logic       fill_ack;
   logic       be_req;
   addr_t      be_addr;
   word_t      be_wdata;
   strb_t      be_wstrb;
   word_t      be_rdata;
   logic       be_ack;

   cache_control i_cache_control (
      .clk_i, .rst_i, .req_i, .addr_i, .wdata_i, .wstrb_i, .rdata_o, .ack_o,
      .invalidate_i,
      .hit_i            (hit),
      .line_word_i      (line_word),
      .mem_we_o         (mem_we),
      .mem_fill_o       (mem_fill),
      .mem_index_o      (mem_index),
      .mem_offset_o     (mem_offset),
      .mem_tag_o        (mem_tag),
      .mem_wdata_o      (mem_wdata),
      .mem_wstrb_o      (mem_wstrb),
      .mem_invalidate_o (mem_invalidate),
      .wtb_push_o       (wtb_push),
      .wtb_entry_o      (wtb_entry),
      .wtb_full_i       (wtb_full),
      .wtb_empty_i      (wtb_empty),
      .fill_req_o       (fill_req),
      .fill_addr_o      (fill_addr),
      .fill_rdata_i     (fill_rdata),
      .fill_ack_i       (fill_ack)
   );

   cache_memory i_cache_memory (
      .clk_i, .rst_i,
      .index_i      (mem_index),
      .offset_i     (mem_offset),
      .tag_i        (mem_tag),
      .we_i         (mem_we),
      .fill_i       (mem_fill),
      .wdata_i      (mem_wdata),
      .wstrb_i      (mem_wstrb),
      .invalidate_i (mem_invalidate),
      .hit_o        (hit),
      .rdata_o      (line_word)
   );

   write_through_buffer i_write_through_buffer (
      .clk_i, .rst_i,
      .push_i  (wtb_push),
      .entry_i (wtb_entry),
      .full_o  (wtb_full),
      .empty_o (wtb_empty),
      .head_o  (wtb_head),
      .pop_i   (wtb_pop)
   );

   backend_arbiter i_backend_arbiter (
      .clk_i, .rst_i,
      .fill_req_i   (fill_req),
      .fill_addr_i  (fill_addr),
      .fill_ack_o   (fill_ack),
      .fill_rdata_o (fill_rdata),
      .wtb_valid_i  (!wtb_empty),
      .wtb_head_i   (wtb_head),
      .wtb_pop_o    (wtb_pop),
      .be_req_o     (be_req),
      .be_addr_o    (be_addr),
      .be_wdata_o   (be_wdata),
      .be_wstrb_o   (be_wstrb),
      .be_rdata_i   (be_rdata),
      .be_ack_i     (be_ack)
   );

   backend_ram i_backend_ram (
      .clk_i, .rst_i,
      .req_i   (be_req),
      .addr_i  (be_addr),
      .wdata_i (be_wdata),
      .wstrb_i (be_wstrb),
      .rdata_o (be_rdata),
      .ack_o   (be_ack)
   );

   assign wtb_empty_o = wtb_empty;

endmodule

// File: sources.f
+incdir+common
common/cache_pkg.sv
cache/cache_memory.sv
cache/write_through_buffer.sv
cache/backend_arbiter.sv
cache/cache_control.sv
source/backend_ram.sv
source/cache_subsystem.sv
testbench/tb_clock.sv
testbench/tb_cache_subsystem.sv

// File: testbench/tb_cache_subsystem.sv
module tb_cache_subsystem;
   timeunit 1ns;
   timeprecision 1ps;
   import cache_pkg::*;

   typedef enum logic [1:0] {OP_READ, OP_WRITE, OP_INVAL, OP_DRAIN} op_kind_e;

   typedef struct packed {
      op_kind_e   kind;
      logic [2:0] test;
      addr_t      addr;
      word_t      data;
      strb_t      strb;
   } op_t;

   logic  clk;
   logic  rst;
   logic  req;
   addr_t addr;
   word_t wdata;
   strb_t wstrb;
   word_t rdata;
   logic  ack;
   logic  invalidate;
   logic  wtb_empty;

   op_t         ops [$];
   word_t       ref_mem [1 << $bits(addr_t)];
   logic [31:0] lfsr_q;
   string       test_names [5];
   int          total_ops;
   int          checks;
   int          errors;
   int          test_errors;
   int          tests_failed;

   tb_clock i_tb_clock (.clk_o(clk), .rst_o(rst));

   cache_subsystem i_cache_subsystem (
      .clk_i        (clk),
      .rst_i        (rst),
      .req_i        (req),
      .addr_i       (addr),
      .wdata_i      (wdata),
      .wstrb_i      (wstrb),
      .rdata_o      (rdata),
      .ack_o        (ack),
      .invalidate_i (invalidate),
      .wtb_empty_o  (wtb_empty)
   );

   // Galois form with taps of x^32 + x^22 + x^2 + x + 1.
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      logic [31:0] n;
      n = s >> 1;
      if (s[0]) n = n ^ 32'h8020_0003;
      return n;
   endfunction

   task automatic take_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         v = {v[30:0], lfsr_q[0]};
         lfsr_q = lfsr_next(lfsr_q);
      end
   endtask

   function automatic word_t merge_bytes(input word_t old, input word_t data, input strb_t strb);
      word_t w;
      w = old;
      for (int b = 0; b < $bits(strb_t); b++) begin
         if (strb[b]) w[8*b +: 8] = data[8*b +: 8];
      end
      return w;
   endfunction

   task automatic check_word(input string name, input word_t got, input word_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         test_errors++;
         $display("[ERROR] %0d ns %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      checks++;
      if (got !== exp) begin
         errors++;
         test_errors++;
         $display("[ERROR] %0d ns %s got %b expected %b", $time, name, got, exp);
      end
   endtask

   task automatic add_op(input op_kind_e kind, input int test, input addr_t a,
                         input word_t d, input strb_t s);
      op_t op;
      op.kind = kind;
      op.test = 3'(test);
      op.addr = a;
      op.data = d;
      op.strb = s;
      ops.push_back(op);
   endtask

   task automatic build_table();
      logic [31:0] k;
      logic [31:0] t;
      logic [31:0] idx;
      logic [31:0] off;
      logic [31:0] d;
      logic [31:0] s;
      test_names = '{"unwritten reads", "byte merge", "same index", "drain and invalidate",
                     "random"};
      add_op(OP_DRAIN, 0, 12'h000, 32'h0, 4'h0);
      add_op(OP_READ,  0, 12'h040, 32'h0, 4'h0);
      add_op(OP_READ,  0, 12'h040, 32'h0, 4'h0);
      add_op(OP_READ,  0, 12'h123, 32'h0, 4'h0);
      // Line already present, so both writes hit.
      add_op(OP_READ,  1, 12'h050, 32'h0, 4'h0);
      add_op(OP_WRITE, 1, 12'h050, 32'h1122_3344, 4'hf);
      add_op(OP_WRITE, 1, 12'h050, 32'haabb_ccdd, 4'b0101);
      add_op(OP_READ,  1, 12'h050, 32'h0, 4'h0);
      // Line never read, so both writes miss.
      add_op(OP_WRITE, 1, 12'h0a4, 32'hdead_beef, 4'hf);
      add_op(OP_WRITE, 1, 12'h0a4, 32'h0102_0304, 4'b1000);
      add_op(OP_READ,  1, 12'h0a4, 32'h0, 4'h0);
      add_op(OP_WRITE, 2, 12'h08d, 32'h0a0a_0a0a, 4'hf);
      add_op(OP_WRITE, 2, 12'h14d, 32'h0b0b_0b0b, 4'hf);
      add_op(OP_READ,  2, 12'h08d, 32'h0, 4'h0);
      add_op(OP_READ,  2, 12'h14d, 32'h0, 4'h0);
      add_op(OP_WRITE, 2, 12'h08d, 32'hc0de_0001, 4'b0011);
      add_op(OP_READ,  2, 12'h14d, 32'h0, 4'h0);
      add_op(OP_READ,  2, 12'h08d, 32'h0, 4'h0);
      add_op(OP_READ,  2, 12'h14d, 32'h0, 4'h0);
      for (int i = 0; i < 6; i++) begin
         add_op(OP_WRITE, 3, addr_t'(12'h200 + i), 32'h5a00_0000 + i, 4'hf);
      end
      add_op(OP_DRAIN, 3, 12'h000, 32'h0, 4'h0);
      add_op(OP_READ,  3, 12'h200, 32'h0, 4'h0);
      add_op(OP_INVAL, 3, 12'h000, 32'h0, 4'h0);
      add_op(OP_READ,  3, 12'h200, 32'h0, 4'h0);
      add_op(OP_READ,  3, 12'h205, 32'h0, 4'h0);
      add_op(OP_READ,  3, 12'h08d, 32'h0, 4'h0);
      add_op(OP_DRAIN, 3, 12'h000, 32'h0, 4'h0);
      // Two tags over four lines keep conflicts frequent.
      for (int i = 0; i < 64; i++) begin
         take_bits(1, k);
         take_bits(1, t);
         take_bits(2, idx);
         take_bits(2, off);
         if (k[0]) begin
            take_bits(32, d);
            take_bits(4, s);
            if (s[3:0] == 4'h0) s = 32'hf;
            add_op(OP_WRITE, 4, {5'd0, t[0], 2'd0, idx[1:0], off[1:0]}, d, s[3:0]);
         end else begin
            add_op(OP_READ, 4, {5'd0, t[0], 2'd0, idx[1:0], off[1:0]}, 32'h0, 4'h0);
         end
      end
   endtask

   task automatic run_op(input op_t op);
      if (op.kind == OP_READ || op.kind == OP_WRITE) begin
         @(posedge clk);
         req   <= 1'b1;
         addr  <= op.addr;
         wdata <= op.data;
         wstrb <= (op.kind == OP_WRITE) ? op.strb : 4'h0;
         do @(negedge clk); while (!ack);
         if (op.kind == OP_READ) begin
            check_word("rdata_o", rdata, ref_mem[op.addr]);
         end else begin
            ref_mem[op.addr] = merge_bytes(ref_mem[op.addr], op.data, op.strb);
         end
         @(posedge clk);
         req   <= 1'b0;
         wstrb <= 4'h0;
      end else if (op.kind == OP_INVAL) begin
         @(posedge clk);
         invalidate <= 1'b1;
         @(posedge clk);
         invalidate <= 1'b0;
      end else begin
         do @(negedge clk); while (!wtb_empty);
         repeat (8) begin
            @(negedge clk);
            check_flag("wtb_empty_o", wtb_empty, 1'b1);
         end
      end
   endtask

   initial begin : watchdog
      wait (total_ops > 0);
      repeat (200 * total_ops) @(posedge clk);
      $display("Timeout after %0d cycles, the DUT stopped answering", 200 * total_ops);
      $display("TEST RESULT: FAIL");
      $finish;
   end

   initial begin
      int test_ops;
      req        = 1'b0;
      addr       = '0;
      wdata      = '0;
      wstrb      = '0;
      invalidate = 1'b0;
      lfsr_q     = 32'h6be6;
      checks     = 0;
      errors     = 0;
      tests_failed = 0;
      foreach (ref_mem[i]) ref_mem[i] = '0;
      build_table();
      total_ops = ops.size();
      wait (!rst);
      test_errors = 0;
      test_ops    = 0;
      foreach (ops[i]) begin
         run_op(ops[i]);
         test_ops++;
         if (i == ops.size() - 1 || ops[i + 1].test != ops[i].test) begin
            $display("test %0d %s: %0d ops, %0d errors, %s", ops[i].test,
                     test_names[ops[i].test], test_ops, test_errors,
                     (test_errors == 0) ? "ok" : "failed");
            if (test_errors != 0) tests_failed++;
            test_errors = 0;
            test_ops    = 0;
         end
      end
      $display("%0d tests, %0d failed, %0d checks, %0d errors", 5, tests_failed, checks, errors);
      if (errors == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

// File: testbench/tb_clock.sv
module tb_clock (
   output logic clk_o,
   output logic rst_o
);
   timeunit 1ns;
   timeprecision 1ps;

   initial begin
      clk_o = 1'b0;
      forever #5 clk_o = ~clk_o;
   end

   // Reset held for the first four rising edges.
   initial begin
      rst_o = 1'b1;
      repeat (4) @(posedge clk_o);
      rst_o <= 1'b0;
   end

endmodule
